// ==== Bender.yml ====
package:
  name: qvga_display

sources:
  - vga_pkg.sv
  - vga_driver.sv
  - qvga_addr_gen.sv
  - frame_buffer.sv
  - vga_pixel_out.sv
  - vga_top.sv
  - target: test
    files:
      - vga_properties.sv
      - vga_tb.sv

// ==== files.f ====
vga_pkg.sv
vga_driver.sv
qvga_addr_gen.sv
frame_buffer.sv
vga_pixel_out.sv
vga_top.sv
vga_properties.sv
vga_tb.sv

// ==== frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer import vga_pkg::*; #(
    parameter int depth = IMG_W * IMG_H
) (
    input  logic      i_clk25m,
    input  logic      i_wr_en,
    input  pix_addr_t i_wr_addr,
    input  pixel_t    i_wr_data,
    input  pix_addr_t i_rd_addr,
    output pixel_t    o_rd_data
);

    // Image storage, one pixel per word
    pixel_t mem [depth];

    // Write port, one word per enabled cycle
    always_ff @(posedge i_clk25m) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Registered read port
    // Same address collision returns the old word
    always_ff @(posedge i_clk25m) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// ==== qvga_addr_gen.sv ====
`timescale 1ns/1ps

module qvga_addr_gen import vga_pkg::*; #(
    parameter int img_w  = IMG_W,
    parameter int img_h  = IMG_H,
    parameter int img_x0 = IMG_X0,
    parameter int img_y0 = IMG_Y0
) (
    input  logic        i_clk25m,
    input  logic        i_reset,
    input  vga_timing_t i_timing,
    output vga_timing_t o_timing,
    output logic        o_active,
    output pix_addr_t   o_rd_addr
);

    // Image window on the raster, end bounds exclusive
    localparam logic [9:0] x_start = 10'(img_x0);
    localparam logic [9:0] x_end   = 10'(img_x0 + img_w);
    localparam logic [9:0] y_start = 10'(img_y0);
    localparam logic [9:0] y_end   = 10'(img_y0 + img_h);

    // Words per image row
    localparam pix_addr_t row_words = pix_addr_t'(img_w);

    logic       in_win;
    logic [9:0] rel_x;
    logic [9:0] rel_y;
    pix_addr_t  next_addr;

    assign in_win = (i_timing.x >= x_start) && (i_timing.x < x_end) &&
                    (i_timing.y >= y_start) && (i_timing.y < y_end);

    // Offset into the image
    assign rel_x = i_timing.x - x_start;
    assign rel_y = i_timing.y - y_start;

    // Row major linear address
    assign next_addr = pix_addr_t'(rel_y) * row_words + pix_addr_t'(rel_x);

    // Flag and timing travel with the address
    always_ff @(posedge i_clk25m) begin
        if (i_reset) begin
            o_timing <= TIMING_IDLE;
            o_active <= 1'b0;
        end else begin
            o_timing <= i_timing;
            o_active <= in_win;
        end
    end

    // Outside the window park on word 0 so the RAM never sees an out of range address
    always_ff @(posedge i_clk25m) begin
        o_rd_addr <= in_win ? next_addr : '0;
    end

endmodule

// ==== vga_driver.sv ====
`timescale 1ns/1ps

module vga_driver import vga_pkg::*; #(
    parameter int h_disp  = H_DISP,
    parameter int h_fp    = H_FP,
    parameter int h_pulse = H_PULSE,
    parameter int h_bp    = H_BP,
    parameter int v_disp  = V_DISP,
    parameter int v_fp    = V_FP,
    parameter int v_pulse = V_PULSE,
    parameter int v_bp    = V_BP
) (
    input  logic        i_clk25m,
    input  logic        i_reset,
    output vga_timing_t o_timing
);

    // Line and frame periods
    localparam int h_total = h_disp + h_fp + h_pulse + h_bp;
    localparam int v_total = v_disp + v_fp + v_pulse + v_bp;

    // Last count before each counter wraps
    localparam logic [9:0] h_last = 10'(h_total - 1);
    localparam logic [9:0] v_last = 10'(v_total - 1);

    // Sync pulse starts after the front porch
    localparam logic [9:0] hs_start = 10'(h_disp + h_fp);
    localparam logic [9:0] hs_end   = 10'(h_disp + h_fp + h_pulse);
    localparam logic [9:0] vs_start = 10'(v_disp + v_fp);
    localparam logic [9:0] vs_end   = 10'(v_disp + v_fp + v_pulse);

    // Visible area limits
    localparam logic [9:0] h_vis = 10'(h_disp);
    localparam logic [9:0] v_vis = 10'(v_disp);

    logic [9:0] x_cnt;
    logic [9:0] y_cnt;
    logic       x_wrap;

    // End of line strobe, steps the line counter
    assign x_wrap = (x_cnt == h_last);

    // Pixel counter, runs on every clock
    always_ff @(posedge i_clk25m) begin
        if (i_reset) begin
            x_cnt <= '0;
        end else if (x_wrap) begin
            x_cnt <= '0;
        end else begin
            x_cnt <= x_cnt + 10'd1;
        end
    end

    // Line counter
    always_ff @(posedge i_clk25m) begin
        if (i_reset) begin
            y_cnt <= '0;
        end else if (x_wrap) begin
            if (y_cnt == v_last) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + 10'd1;
            end
        end
    end

    // Decode straight from the registered counters
    always_comb begin
        o_timing.x     = x_cnt;
        o_timing.y     = y_cnt;
        // Active low pulses
        o_timing.hsync = !((x_cnt >= hs_start) && (x_cnt < hs_end));
        o_timing.vsync = !((y_cnt >= vs_start) && (y_cnt < vs_end));
        o_timing.video = (x_cnt < h_vis) && (y_cnt < v_vis);
    end

endmodule

// ==== vga_pixel_out.sv ====
`timescale 1ns/1ps

module vga_pixel_out import vga_pkg::*; (
    input  logic        i_clk25m,
    input  logic        i_reset,
    input  vga_timing_t i_timing,
    input  logic        i_active,
    input  pixel_t      i_pixel,
    output vga_timing_t o_timing,
    output pixel_t      o_rgb
);

    vga_timing_t timing_d;
    logic        active_d;

    // Hold timing and flag one cycle to meet the RAM read data
    always_ff @(posedge i_clk25m) begin
        if (i_reset) begin
            timing_d <= TIMING_IDLE;
            active_d <= 1'b0;
        end else begin
            timing_d <= i_timing;
            active_d <= i_active;
        end
    end

    // Output register
    // Reset keeps the syncs inactive and the screen black
    always_ff @(posedge i_clk25m) begin
        if (i_reset) begin
            o_timing <= TIMING_IDLE;
            o_rgb    <= PIXEL_BLACK;
        end else begin
            o_timing <= timing_d;
            // Border around the image is black
            o_rgb    <= active_d ? i_pixel : PIXEL_BLACK;
        end
    end

endmodule

// ==== vga_pkg.sv ====
package vga_pkg;

    // Position and sync state of one pixel slot
    // Syncs are active low, video is active high
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       hsync;
        logic       vsync;
        logic       video;
    } vga_timing_t;

    // 12-bit RGB pixel, 4 bits per channel
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pixel_t;

    // Frame buffer word address, 320x240 = 76800 words
    typedef logic [16:0] pix_addr_t;

    // Default 640x480 horizontal timing in pixels
    localparam int H_DISP  = 640;
    localparam int H_FP    = 16;
    localparam int H_PULSE = 96;
    localparam int H_BP    = 48;

    // Default vertical timing in lines
    localparam int V_DISP  = 480;
    localparam int V_FP    = 10;
    localparam int V_PULSE = 2;
    localparam int V_BP    = 33;

    // QVGA image centered on the visible area
    localparam int IMG_W  = 320;
    localparam int IMG_H  = 240;
    localparam int IMG_X0 = 160;
    localparam int IMG_Y0 = 120;

    // Timing value shown while the pipeline is held in reset
    localparam vga_timing_t TIMING_IDLE = '{
        x:     '0,
        y:     '0,
        hsync: 1'b1,
        vsync: 1'b1,
        video: 1'b0
    };

    localparam pixel_t PIXEL_BLACK = '0;

endpackage

// ==== vga_properties.sv ====
`timescale 1ns/1ps

module vga_properties import vga_pkg::*; (
    input logic        i_clk25m,
    input logic        i_reset,
    input vga_timing_t i_vga,
    input pixel_t      i_rgb
);

    localparam int h_total  = H_DISP + H_FP + H_PULSE + H_BP;
    localparam int hs_start = H_DISP + H_FP;
    localparam int hs_end   = H_DISP + H_FP + H_PULSE;

    // Nothing is drawn while blanked
    a_black_blank: assert property (
        @(posedge i_clk25m) disable iff (i_reset)
        !i_vga.video |-> (i_rgb == '0)
    ) else $error("o_rgb is not black while video is low");

    // Video only inside the visible area
    a_video_area: assert property (
        @(posedge i_clk25m) disable iff (i_reset)
        i_vga.video |-> ((i_vga.x < H_DISP) && (i_vga.y < V_DISP))
    ) else $error("video high outside the visible area");

    // Horizontal pulse confined to 656..751
    a_hsync_range: assert property (
        @(posedge i_clk25m) disable iff (i_reset)
        !i_vga.hsync |-> ((i_vga.x >= hs_start) && (i_vga.x < hs_end))
    ) else $error("hsync low outside the pulse range");

    a_x_bound: assert property (
        @(posedge i_clk25m) disable iff (i_reset)
        i_vga.x < h_total
    ) else $error("o_vga x reached the line period");

endmodule

bind vga_top vga_properties i_vga_properties (
    .i_clk25m (i_clk25m),
    .i_reset  (i_reset),
    .i_vga    (o_vga),
    .i_rgb    (o_rgb)
);

// ==== vga_tb.sv ====
`timescale 1ns/1ps

module vga_tb import vga_pkg::*; ();

    localparam int H_TOTAL      = H_DISP + H_FP + H_PULSE + H_BP;
    localparam int V_TOTAL      = V_DISP + V_FP + V_PULSE + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int IMG_WORDS    = IMG_W * IMG_H;
    localparam int RESET_CYCLES = 8;
    // Driver to o_vga latency in cycles
    localparam int PIPE_DEPTH   = 3;
    // Reset + fill + two frames is about 917k cycles, rounded up
    localparam int TIMEOUT_CYCLES = 1_000_000;
    localparam time DRIVE_DLY   = 1ns;

    logic        clk;
    logic        reset;
    logic        wr_en;
    pix_addr_t   wr_addr;
    pixel_t      wr_data;
    vga_timing_t vga;
    pixel_t      rgb;

    // Reference image and the cycle each word was last written
    pixel_t model_mem [IMG_WORDS];
    int     wr_cycle [IMG_WORDS];

    int cycle_cnt = 0;
    int seed_val;
    int exp_x;
    int exp_y;
    int pixel_checks = 0;
    int blank_checks = 0;
    // Idle cycles left after reset while the pipeline fills
    int idle_left = PIPE_DEPTH - 1;
    bit fill_done = 0;
    bit model_started = 0;

    vga_top i_vga_top (
        .i_clk25m  (clk),
        .i_reset   (reset),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .o_vga     (vga),
        .o_rgb     (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Cycle stamp, also bounds the run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("Timeout, the run did not finish within the cycle limit");
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_timing(input vga_timing_t got, input vga_timing_t exp,
                                input string name);
        if (got !== exp) begin
            fail_run($sformatf({"Mismatch at %0t: %s got x=%0d y=%0d hs=%b vs=%b vid=%b,",
                                " expected x=%0d y=%0d hs=%b vs=%b vid=%b"},
                               $time, name, got.x, got.y, got.hsync, got.vsync, got.video,
                               exp.x, exp.y, exp.hsync, exp.vsync, exp.video));
        end
    endtask

    task automatic check_pixel(input pixel_t got, input pixel_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    // Sync and video levels straight from the 640x480 timing rules
    function automatic vga_timing_t decode_timing(input int x, input int y);
        vga_timing_t t;
        t.x     = 10'(x);
        t.y     = 10'(y);
        t.hsync = !((x >= H_DISP + H_FP) && (x < H_DISP + H_FP + H_PULSE));
        t.vsync = !((y >= V_DISP + V_FP) && (y < V_DISP + V_FP + V_PULSE));
        t.video = (x < H_DISP) && (y < V_DISP);
        return t;
    endfunction

    function automatic pixel_t rand_pixel();
        return pixel_t'(12'($urandom));
    endfunction

    // Drives one write and mirrors it in the model
    task automatic write_word(input int addr, input pixel_t data);
        wr_en           = 1'b1;
        wr_addr         = pix_addr_t'(addr);
        wr_data         = data;
        model_mem[addr] = data;
        wr_cycle[addr]  = cycle_cnt;
    endtask

    // Runs once per cycle, just after the outputs settle
    task automatic check_cycle();
        vga_timing_t exp;
        pixel_t      black;
        int          cx;
        int          cy;
        int          addr;
        bit          in_win;
        black = '0;
        if (reset || (idle_left > 0)) begin
            // Idle output in reset and until the pipeline has filled
            exp       = '0;
            exp.hsync = 1'b1;
            exp.vsync = 1'b1;
            check_timing(vga, exp, "o_vga");
            check_pixel(rgb, black, "o_rgb");
            if (!reset) begin
                idle_left--;
            end
        end else begin
            if (fill_done && !model_started) begin
                // First slot after the fill seeds the raster model
                model_started = 1'b1;
                exp_x = vga.x;
                exp_y = vga.y;
            end else if (model_started) begin
                if (exp_x == H_TOTAL - 1) begin
                    exp_x = 0;
                    exp_y = (exp_y == V_TOTAL - 1) ? 0 : exp_y + 1;
                end else begin
                    exp_x = exp_x + 1;
                end
            end
            cx = model_started ? exp_x : int'(vga.x);
            cy = model_started ? exp_y : int'(vga.y);
            check_timing(vga, decode_timing(cx, cy), "o_vga");
            in_win = (cx >= IMG_X0) && (cx < IMG_X0 + IMG_W) &&
                     (cy >= IMG_Y0) && (cy < IMG_Y0 + IMG_H);
            if (!in_win) begin
                check_pixel(rgb, black, "o_rgb");
                blank_checks++;
            end else if (model_started) begin
                addr = (cy - IMG_Y0) * IMG_W + (cx - IMG_X0);
                // Words written in the last few cycles may still be in flight
                if (cycle_cnt - wr_cycle[addr] > 4) begin
                    check_pixel(rgb, model_mem[addr], "o_rgb");
                    pixel_checks++;
                end
            end
        end
    endtask

    initial begin
        seed_val = $urandom(4994);
        reset    = 1'b1;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        for (int a = 0; a < IMG_WORDS; a++) begin
            wr_cycle[a] = -100;
        end

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_cycle();
        end
        reset = 1'b0;

        // Fill the whole image while the raster runs
        for (int a = 0; a < IMG_WORDS; a++) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_cycle();
            write_word(a, rand_pixel());
        end
        fill_done = 1'b1;

        // Two full frames with sparse random overwrites
        repeat (2 * FRAME_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_cycle();
            if ($urandom_range(63) == 0) begin
                write_word($urandom_range(IMG_WORDS - 1), rand_pixel());
            end else begin
                wr_en = 1'b0;
            end
        end

        if ((pixel_checks > 0) && (blank_checks > 0)) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run("No image or border pixels were checked");
        end
    end

endmodule

// ==== vga_top.sv ====
`timescale 1ns/1ps

module vga_top import vga_pkg::*; #(
    parameter int h_disp  = H_DISP,
    parameter int h_fp    = H_FP,
    parameter int h_pulse = H_PULSE,
    parameter int h_bp    = H_BP,
    parameter int v_disp  = V_DISP,
    parameter int v_fp    = V_FP,
    parameter int v_pulse = V_PULSE,
    parameter int v_bp    = V_BP,
    parameter int img_w   = IMG_W,
    parameter int img_h   = IMG_H,
    parameter int img_x0  = IMG_X0,
    parameter int img_y0  = IMG_Y0
) (
    input  logic        i_clk25m,
    input  logic        i_reset,
    // Frame buffer fill port
    input  logic        i_wr_en,
    input  pix_addr_t   i_wr_addr,
    input  pixel_t      i_wr_data,
    // Display outputs
    output vga_timing_t o_vga,
    output pixel_t      o_rgb
);

    // Count stage to address stage
    vga_timing_t count_timing;

    // Address stage to RAM and output stage
    vga_timing_t addr_timing;
    logic        addr_active;
    pix_addr_t   rd_addr;

    // RAM read data
    pixel_t      rd_pixel;

    vga_driver #(
        .h_disp  (h_disp),
        .h_fp    (h_fp),
        .h_pulse (h_pulse),
        .h_bp    (h_bp),
        .v_disp  (v_disp),
        .v_fp    (v_fp),
        .v_pulse (v_pulse),
        .v_bp    (v_bp)
    ) i_vga_driver (
        .i_clk25m (i_clk25m),
        .i_reset  (i_reset),
        .o_timing (count_timing)
    );

    qvga_addr_gen #(
        .img_w  (img_w),
        .img_h  (img_h),
        .img_x0 (img_x0),
        .img_y0 (img_y0)
    ) i_qvga_addr_gen (
        .i_clk25m  (i_clk25m),
        .i_reset   (i_reset),
        .i_timing  (count_timing),
        .o_timing  (addr_timing),
        .o_active  (addr_active),
        .o_rd_addr (rd_addr)
    );

    // One word per image pixel
    frame_buffer #(
        .depth (img_w * img_h)
    ) i_frame_buffer (
        .i_clk25m  (i_clk25m),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_pixel)
    );

    vga_pixel_out i_vga_pixel_out (
        .i_clk25m (i_clk25m),
        .i_reset  (i_reset),
        .i_timing (addr_timing),
        .i_active (addr_active),
        .i_pixel  (rd_pixel),
        .o_timing (o_vga),
        .o_rgb    (o_rgb)
    );

endmodule
